//--- include/move_ctrl_defines.svh
`ifndef MOVE_CTRL_DEFINES_SVH
`define MOVE_CTRL_DEFINES_SVH

`define SIDE_WIDTH          32   // 8 squares of 4 bits
`define BOARD_WIDTH         (8 * `SIDE_WIDTH)
`define MAX_POSITIONS_LOG2  7
`define HALF_MOVE_WIDTH     8

`define AXI_ADDR_WIDTH      40   // Byte address on the AXI4-Lite port
`define REG_ADDR_WIDTH      10   // Byte address bits 11:2

`define ADDR_CONTROL        0
`define ADDR_MOVE_INDEX     1
`define ADDR_POSITION       2
`define ADDR_HALF_MOVE      3
`define ADDR_BOARD_BASE     8    // Ranks 0 to 7 at words 8 to 15
`define ADDR_STATUS         32
`define ADDR_MOVE_COUNT     33

`define QUEUE_DEPTH         2

`endif

//--- verilog/chess_pkg.sv
`default_nettype none

`include "move_ctrl_defines.svh"

package chess_pkg;

   // One rank of the board, 4 bits per square
   typedef logic [`SIDE_WIDTH-1:0] rank_t;

   // Rank 0 in the low word
   typedef rank_t [7:0] board_t;

   typedef logic [3:0] castle_mask_t;

   typedef logic [3:0] ep_col_t;

   typedef logic [`MAX_POSITIONS_LOG2-1:0] move_index_t;   // Index and count

   typedef logic [`HALF_MOVE_WIDTH-1:0] half_move_t;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

`include "move_ctrl_defines.svh"

package bus_pkg;

   // Word address into the register bank
   typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

   typedef struct packed {
      reg_addr_t   addr;
      logic [31:0] data;
   } wr_req_t;

   typedef struct packed {
      reg_addr_t addr;
   } rd_req_t;

endpackage

`default_nettype wire

//--- verilog/req_queue.sv
`default_nettype none

module req_queue #(
   parameter type payload_t = logic [31:0],
   parameter int  depth     = 2
) (
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic push,
   input  payload_t  push_data,
   output logic      full,
   input  wire logic pop,
   output payload_t  head,
   output logic      not_empty
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign full      = (count == cnt_w'(depth));
   assign not_empty = (count != '0);
   assign do_push   = push && !full;
   assign do_pop    = pop && not_empty;
   assign head      = mem[rd_ptr];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

endmodule

`default_nettype wire

//--- verilog/axi_wr_front.sv
`default_nettype none

`include "move_ctrl_defines.svh"

module axi_wr_front
   import bus_pkg::*;
(
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] axi_awaddr,
   input  wire logic                       axi_awvalid,
   output logic                            axi_awready,
   input  wire logic [31:0]                axi_wdata,
   input  wire logic                       axi_wvalid,
   output logic                            axi_wready,
   output logic                            axi_bvalid,
   input  wire logic                       axi_bready,
   output logic [1:0]                      axi_bresp,
   output logic                            wr_req,
   output wr_req_t                         wr_head,
   input  wire logic                       wr_grant
);

   logic        aw_held;
   logic        w_held;
   reg_addr_t   aw_addr;
   logic [31:0] w_data;
   logic        q_full;
   logic        q_not_empty;
   logic        join_push;
   wr_req_t     join_req;

   assign axi_awready = !aw_held;
   assign axi_wready  = !w_held;
   assign axi_bresp   = 2'b00;   // Always OKAY
   assign join_push   = aw_held && w_held && !q_full;
   assign join_req    = '{addr: aw_addr, data: w_data};
   assign wr_req      = q_not_empty && !axi_bvalid;   // One B outstanding at a time

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         aw_held    <= 1'b0;
         w_held     <= 1'b0;
         axi_bvalid <= 1'b0;
      end
      else
      begin
         if (join_push)
            aw_held <= 1'b0;
         else if (axi_awvalid && axi_awready)
            aw_held <= 1'b1;
         if (join_push)
            w_held <= 1'b0;
         else if (axi_wvalid && axi_wready)
            w_held <= 1'b1;
         if (wr_grant)
            axi_bvalid <= 1'b1;
         else if (axi_bready)
            axi_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (axi_awvalid && axi_awready)
         aw_addr <= axi_awaddr[`REG_ADDR_WIDTH+1:2];
      if (axi_wvalid && axi_wready)
         w_data <= axi_wdata;   // Strobes ignored
   end

   req_queue #(
      .payload_t (wr_req_t),
      .depth     (`QUEUE_DEPTH)
   ) u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (join_push),
      .push_data (join_req),
      .full      (q_full),
      .pop       (wr_grant),
      .head      (wr_head),
      .not_empty (q_not_empty)
   );

endmodule

`default_nettype wire

//--- verilog/axi_rd_front.sv
`default_nettype none

`include "move_ctrl_defines.svh"

module axi_rd_front
   import bus_pkg::*;
(
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] axi_araddr,
   input  wire logic                       axi_arvalid,
   output logic                            axi_arready,
   output logic [31:0]                     axi_rdata,
   output logic                            axi_rvalid,
   input  wire logic                       axi_rready,
   output logic [1:0]                      axi_rresp,
   output logic                            rd_req,
   output rd_req_t                         rd_head,
   input  wire logic                       rd_grant,
   input  wire logic [31:0]                rd_data
);

   logic    q_full;
   logic    q_not_empty;
   logic    ar_push;
   rd_req_t ar_req;

   assign axi_arready = !q_full;
   assign axi_rresp   = 2'b00;
   assign ar_push     = axi_arvalid && axi_arready;
   assign ar_req      = '{addr: axi_araddr[`REG_ADDR_WIDTH+1:2]};
   assign rd_req      = q_not_empty && !axi_rvalid;   // Response slot must be free

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         axi_rvalid <= 1'b0;
      else if (rd_grant)
         axi_rvalid <= 1'b1;
      else if (axi_rready)
         axi_rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (rd_grant)
         axi_rdata <= rd_data;   // Bank data seen at grant
   end

   req_queue #(
      .payload_t (rd_req_t),
      .depth     (`QUEUE_DEPTH)
   ) u_queue (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (ar_push),
      .push_data (ar_req),
      .full      (q_full),
      .pop       (rd_grant),
      .head      (rd_head),
      .not_empty (q_not_empty)
   );

endmodule

`default_nettype wire

//--- verilog/reg_arbiter.sv
`default_nettype none

module reg_arbiter
   import bus_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic wr_req,
   input  wr_req_t   wr_head,
   output logic      wr_grant,
   input  wire logic rd_req,
   input  rd_req_t   rd_head,
   output logic      rd_grant,
   output logic      bank_en,
   output logic      bank_we,
   output reg_addr_t bank_addr,
   output logic [31:0] bank_wdata
);

   logic last_wr;   // Write front won the last grant

   // On a tie the front not served last goes first
   assign wr_grant = wr_req && (!rd_req || !last_wr);
   assign rd_grant = rd_req && !wr_grant;

   assign bank_en    = wr_grant || rd_grant;
   assign bank_we    = wr_grant;
   assign bank_addr  = wr_grant ? wr_head.addr : rd_head.addr;
   assign bank_wdata = wr_head.data;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         last_wr <= 1'b0;
      else if (wr_grant)
         last_wr <= 1'b1;
      else if (rd_grant)
         last_wr <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verilog/ctrl_reg_bank.sv
`default_nettype none

`include "move_ctrl_defines.svh"

module ctrl_reg_bank
   import chess_pkg::*;
   import bus_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        bank_en,
   input  wire logic        bank_we,
   input  reg_addr_t        bank_addr,
   input  wire logic [31:0] bank_wdata,
   output logic [31:0]      bank_rdata,
   output logic             new_board_valid,
   output logic             clear_moves,
   output move_index_t      move_index,
   output logic             white_to_move,
   output castle_mask_t     castle_mask,
   output ep_col_t          en_passant_col,
   output half_move_t       half_move,
   output board_t           new_board,
   input  wire logic        gen_idle,
   input  wire logic        moves_ready,
   input  wire logic        move_ready,
   input  move_index_t      move_count
);

   logic [2:0] rank_sel;

   assign rank_sel = bank_addr[2:0];   // Board base is 8-word aligned

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         new_board_valid <= 1'b0;
         clear_moves     <= 1'b0;
         move_index      <= '0;
         white_to_move   <= 1'b0;
         castle_mask     <= '0;
         en_passant_col  <= '0;
         half_move       <= '0;
         new_board       <= '0;
      end
      else if (bank_en && bank_we)
      begin
         case (bank_addr) inside
            `ADDR_CONTROL:
            begin
               new_board_valid <= bank_wdata[0];
               clear_moves     <= bank_wdata[1];
            end
            `ADDR_MOVE_INDEX:
               move_index <= bank_wdata[`MAX_POSITIONS_LOG2-1:0];
            `ADDR_POSITION:
            begin
               white_to_move  <= bank_wdata[8];
               castle_mask    <= bank_wdata[7:4];
               en_passant_col <= bank_wdata[3:0];
            end
            `ADDR_HALF_MOVE:
               half_move <= bank_wdata[`HALF_MOVE_WIDTH-1:0];
            [`ADDR_BOARD_BASE : `ADDR_BOARD_BASE + 7]:
               new_board[rank_sel] <= bank_wdata[`SIDE_WIDTH-1:0];
            default:
            begin
               // Status words and holes are not writable
            end
         endcase
      end
   end

   always_comb
   begin
      bank_rdata = '0;
      case (bank_addr) inside
         `ADDR_CONTROL:
            bank_rdata[1:0] = {clear_moves, new_board_valid};
         `ADDR_MOVE_INDEX:
            bank_rdata[`MAX_POSITIONS_LOG2-1:0] = move_index;
         `ADDR_POSITION:
            bank_rdata[8:0] = {white_to_move, castle_mask, en_passant_col};
         `ADDR_HALF_MOVE:
            bank_rdata[`HALF_MOVE_WIDTH-1:0] = half_move;
         [`ADDR_BOARD_BASE : `ADDR_BOARD_BASE + 7]:
            bank_rdata[`SIDE_WIDTH-1:0] = new_board[rank_sel];
         `ADDR_STATUS:
            bank_rdata[2:0] = {move_ready, moves_ready, gen_idle};
         `ADDR_MOVE_COUNT:
            bank_rdata[`MAX_POSITIONS_LOG2-1:0] = move_count;
         default:
            bank_rdata = '0;   // Unmapped
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/move_ctrl_top.sv
`default_nettype none

`include "move_ctrl_defines.svh"

module move_ctrl_top
   import chess_pkg::*;
   import bus_pkg::*;
(
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] axi_awaddr,
   input  wire logic                       axi_awvalid,
   output logic                            axi_awready,
   input  wire logic [31:0]                axi_wdata,
   input  wire logic                       axi_wvalid,
   output logic                            axi_wready,
   output logic                            axi_bvalid,
   input  wire logic                       axi_bready,
   output logic [1:0]                      axi_bresp,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] axi_araddr,
   input  wire logic                       axi_arvalid,
   output logic                            axi_arready,
   output logic [31:0]                     axi_rdata,
   output logic                            axi_rvalid,
   input  wire logic                       axi_rready,
   output logic [1:0]                      axi_rresp,
   output logic                            new_board_valid,
   output logic                            clear_moves,
   output move_index_t                     move_index,
   output logic                            white_to_move,
   output castle_mask_t                    castle_mask,
   output ep_col_t                         en_passant_col,
   output half_move_t                      half_move,
   output board_t                          new_board,
   input  wire logic                       gen_idle,
   input  wire logic                       moves_ready,
   input  wire logic                       move_ready,
   input  move_index_t                     move_count
);

   logic        wr_req;
   wr_req_t     wr_head;
   logic        wr_grant;
   logic        rd_req;
   rd_req_t     rd_head;
   logic        rd_grant;
   logic        bank_en;
   logic        bank_we;
   reg_addr_t   bank_addr;
   logic [31:0] bank_wdata;
   logic [31:0] bank_rdata;

   axi_wr_front u_wr_front (
      .clk         (clk),
      .rst_n       (rst_n),
      .axi_awaddr  (axi_awaddr),
      .axi_awvalid (axi_awvalid),
      .axi_awready (axi_awready),
      .axi_wdata   (axi_wdata),
      .axi_wvalid  (axi_wvalid),
      .axi_wready  (axi_wready),
      .axi_bvalid  (axi_bvalid),
      .axi_bready  (axi_bready),
      .axi_bresp   (axi_bresp),
      .wr_req      (wr_req),
      .wr_head     (wr_head),
      .wr_grant    (wr_grant)
   );

   axi_rd_front u_rd_front (
      .clk         (clk),
      .rst_n       (rst_n),
      .axi_araddr  (axi_araddr),
      .axi_arvalid (axi_arvalid),
      .axi_arready (axi_arready),
      .axi_rdata   (axi_rdata),
      .axi_rvalid  (axi_rvalid),
      .axi_rready  (axi_rready),
      .axi_rresp   (axi_rresp),
      .rd_req      (rd_req),
      .rd_head     (rd_head),
      .rd_grant    (rd_grant),
      .rd_data     (bank_rdata)
   );

   reg_arbiter u_arbiter (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_req     (wr_req),
      .wr_head    (wr_head),
      .wr_grant   (wr_grant),
      .rd_req     (rd_req),
      .rd_head    (rd_head),
      .rd_grant   (rd_grant),
      .bank_en    (bank_en),
      .bank_we    (bank_we),
      .bank_addr  (bank_addr),
      .bank_wdata (bank_wdata)
   );

   ctrl_reg_bank u_bank (
      .clk             (clk),
      .rst_n           (rst_n),
      .bank_en         (bank_en),
      .bank_we         (bank_we),
      .bank_addr       (bank_addr),
      .bank_wdata      (bank_wdata),
      .bank_rdata      (bank_rdata),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .move_index      (move_index),
      .white_to_move   (white_to_move),
      .castle_mask     (castle_mask),
      .en_passant_col  (en_passant_col),
      .half_move       (half_move),
      .new_board       (new_board),
      .gen_idle        (gen_idle),
      .moves_ready     (moves_ready),
      .move_ready      (move_ready),
      .move_count      (move_count)
   );

endmodule

`default_nettype wire

//--- verif/move_ctrl_assertions.sv
`default_nettype none

module move_ctrl_assertions (
   input wire logic        clk,
   input wire logic        rst_n,
   input wire logic        axi_bvalid,
   input wire logic        axi_bready,
   input wire logic [1:0]  axi_bresp,
   input wire logic        axi_rvalid,
   input wire logic        axi_rready,
   input wire logic [31:0] axi_rdata,
   input wire logic [1:0]  axi_rresp,
   input wire logic        wr_grant,
   input wire logic        rd_grant,
   input wire logic        wr_q_push,
   input wire logic        wr_q_full,
   input wire logic        rd_q_push,
   input wire logic        rd_q_full
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;   // Failed properties so far

   b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      axi_bvalid && !axi_bready |=> axi_bvalid && $stable(axi_bresp))
   else
   begin
      fail_count++;
      $error("B response dropped or changed before bready");
   end

   r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata) && $stable(axi_rresp))
   else
   begin
      fail_count++;
      $error("R response dropped or changed before rready");
   end

   one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_grant && rd_grant))
   else
   begin
      fail_count++;
      $error("Write and read grants high together");
   end

   wr_q_ovf: assert property (@(posedge clk) disable iff (!rst_n)
      !(wr_q_push && wr_q_full))
   else
   begin
      fail_count++;
      $error("Write queue pushed while full");
   end

   rd_q_ovf: assert property (@(posedge clk) disable iff (!rst_n)
      !(rd_q_push && rd_q_full))
   else
   begin
      fail_count++;
      $error("Read queue pushed while full");
   end

endmodule

bind move_ctrl_top move_ctrl_assertions u_assertions (
   .clk        (clk),
   .rst_n      (rst_n),
   .axi_bvalid (axi_bvalid),
   .axi_bready (axi_bready),
   .axi_bresp  (axi_bresp),
   .axi_rvalid (axi_rvalid),
   .axi_rready (axi_rready),
   .axi_rdata  (axi_rdata),
   .axi_rresp  (axi_rresp),
   .wr_grant   (wr_grant),
   .rd_grant   (rd_grant),
   .wr_q_push  (u_wr_front.join_push),
   .wr_q_full  (u_wr_front.q_full),
   .rd_q_push  (u_rd_front.ar_push),
   .rd_q_full  (u_rd_front.q_full)
);

`default_nettype wire

//--- include/move_ctrl_tb_cfg.svh
`ifndef MOVE_CTRL_TB_CFG_SVH
`define MOVE_CTRL_TB_CFG_SVH

`define TB_CLK_PERIOD   40
`define TB_NUM_ROUNDS   40
`define TB_MAX_TXN      16   // Requests per direction in one round
`define TB_TXN_CYCLES   60   // Cycle bound for one transaction

`endif

//--- verif/move_ctrl_tb.sv
`default_nettype none

`include "move_ctrl_defines.svh"
`include "move_ctrl_tb_cfg.svh"

module move_ctrl_tb
   import chess_pkg::*;
   import bus_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int max_txn     = `TB_MAX_TXN;
   localparam int watchdog_ns =
      (`TB_NUM_ROUNDS * 2 * max_txn * `TB_TXN_CYCLES + 200) * `TB_CLK_PERIOD;

   logic                       clk;
   logic                       rst_n;
   logic [`AXI_ADDR_WIDTH-1:0] axi_awaddr;
   logic                       axi_awvalid;
   logic                       axi_awready;
   logic [31:0]                axi_wdata;
   logic                       axi_wvalid;
   logic                       axi_wready;
   logic                       axi_bvalid;
   logic                       axi_bready;
   logic [1:0]                 axi_bresp;
   logic [`AXI_ADDR_WIDTH-1:0] axi_araddr;
   logic                       axi_arvalid;
   logic                       axi_arready;
   logic [31:0]                axi_rdata;
   logic                       axi_rvalid;
   logic                       axi_rready;
   logic [1:0]                 axi_rresp;
   logic                       new_board_valid;
   logic                       clear_moves;
   move_index_t                move_index;
   logic                       white_to_move;
   castle_mask_t               castle_mask;
   ep_col_t                    en_passant_col;
   half_move_t                 half_move;
   board_t                     new_board;
   logic                       gen_idle;
   logic                       moves_ready;
   logic                       move_ready;
   move_index_t                move_count;

   logic [31:0] reg_model [16];   // Expected setup words 0 to 15
   int          wr_addr [max_txn];
   logic [31:0] wr_data [max_txn];
   int          rd_addr [max_txn];
   int          n_wr;
   int          n_rd;
   int          b_count;
   int          r_count;

   move_ctrl_top uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #(`TB_CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Bits a setup word keeps, per the register map
   function automatic logic [31:0] masked_value(input int a, input logic [31:0] data);
      case (a)
         `ADDR_CONTROL:    return data & 32'h0000_0003;
         `ADDR_MOVE_INDEX: return data & 32'h0000_007f;
         `ADDR_POSITION:   return data & 32'h0000_01ff;
         `ADDR_HALF_MOVE:  return data & 32'h0000_00ff;
         default:          return (a >= `ADDR_BOARD_BASE && a < 16) ? data : 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] expect_read(input int a);
      if (a < 16)
         return reg_model[a];
      else if (a == `ADDR_STATUS)
         return {29'h0, move_ready, moves_ready, gen_idle};
      else if (a == `ADDR_MOVE_COUNT)
         return 32'(move_count);
      return 32'h0;   // Unmapped
   endfunction

   task automatic check_outputs();
      check_value("new_board_valid", 32'(new_board_valid), 32'(reg_model[0][0]));
      check_value("clear_moves", 32'(clear_moves), 32'(reg_model[0][1]));
      check_value("move_index", 32'(move_index), reg_model[1]);
      check_value("white_to_move", 32'(white_to_move), 32'(reg_model[2][8]));
      check_value("castle_mask", 32'(castle_mask), 32'(reg_model[2][7:4]));
      check_value("en_passant_col", 32'(en_passant_col), 32'(reg_model[2][3:0]));
      check_value("half_move", 32'(half_move), reg_model[3]);
      for (int i = 0; i < 8; i++)
         check_value($sformatf("new_board[%0d]", i), new_board[i], reg_model[8 + i]);
   endtask

   task automatic idle_gap();
      int g;
      g = $urandom % 5;
      if (g > 2)
         g = 0;   // Mostly back to back
      repeat (g) @(negedge clk);
   endtask

   task automatic send_aw(input int a);
      axi_awaddr  = `AXI_ADDR_WIDTH'(a) << 2;
      axi_awvalid = 1'b1;
      while (!axi_awready) @(negedge clk);
      @(negedge clk);
      axi_awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [31:0] d);
      axi_wdata  = d;
      axi_wvalid = 1'b1;
      while (!axi_wready) @(negedge clk);
      @(negedge clk);
      axi_wvalid = 1'b0;
   endtask

   task automatic send_ar(input int a);
      axi_araddr  = `AXI_ADDR_WIDTH'(a) << 2;
      axi_arvalid = 1'b1;
      while (!axi_arready) @(negedge clk);
      @(negedge clk);
      axi_arvalid = 1'b0;
   endtask

   // Reads avoid the setup words this round writes, so their order is free
   task automatic plan_round(input bit with_writes);
      logic [15:0] mask;
      logic [31:0] rnd;
      int          k;
      int          a;
      rnd         = $urandom;
      gen_idle    = rnd[0];
      moves_ready = rnd[1];
      move_ready  = rnd[2];
      move_count  = rnd[10:4];
      mask        = with_writes ? 16'($urandom) : 16'h0;
      k           = $urandom % 16;
      mask[k]     = 1'b0;
      if (with_writes && mask == 16'h0)
         mask[(k + 1) % 16] = 1'b1;
      n_wr = with_writes ? 1 + $urandom % max_txn : 0;
      n_rd = 1 + $urandom % max_txn;
      for (int i = 0; i < n_wr; i++)
      begin
         if ($urandom % 4 == 0)
            a = 16 + $urandom % 1008;   // Read-only or unmapped
         else
         begin
            do a = $urandom % 16; while (!mask[a]);
         end
         wr_addr[i] = a;
         wr_data[i] = $urandom;
      end
      for (int i = 0; i < n_rd; i++)
      begin
         k = $urandom % 8;
         if (k < 5)
         begin
            do a = $urandom % 16; while (mask[a]);
         end
         else if (k == 5)
            a = `ADDR_STATUS;
         else if (k == 6)
            a = `ADDR_MOVE_COUNT;
         else
            a = 16 + $urandom % 1008;
         rd_addr[i] = a;
      end
   endtask

   task automatic run_round();
      b_count = 0;
      r_count = 0;
      fork
         for (int i = 0; i < n_wr; i++)
         begin
            idle_gap();
            send_aw(wr_addr[i]);
         end
         for (int i = 0; i < n_wr; i++)
         begin
            idle_gap();
            send_w(wr_data[i]);
         end
         for (int i = 0; i < n_rd; i++)
         begin
            idle_gap();
            send_ar(rd_addr[i]);
         end
      join
      wait (b_count == n_wr && r_count == n_rd);
      @(negedge clk);
   endtask

   task automatic readback_round();
      plan_round(1'b0);
      n_rd = 16;
      for (int i = 0; i < 16; i++)
         rd_addr[i] = i;
      run_round();
   endtask

   // Response monitors with random ready stalls
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         axi_bready = ($urandom % 4) != 0;
         if (axi_bvalid && axi_bready)
         begin
            if (b_count >= n_wr)
               stop_on_error("Write response arrived with no write outstanding");
            reg_model[wr_addr[b_count] % 16] = (wr_addr[b_count] < 16) ?
               masked_value(wr_addr[b_count], wr_data[b_count]) :
               reg_model[wr_addr[b_count] % 16];
            check_value("axi_bresp", 32'(axi_bresp), 32'h0);
            check_outputs();
            b_count++;
         end
      end
   end

   always @(negedge clk)
   begin
      if (rst_n)
      begin
         axi_rready = ($urandom % 4) != 0;
         if (axi_rvalid && axi_rready)
         begin
            if (r_count >= n_rd)
               stop_on_error("Read response arrived with no read outstanding");
            check_value($sformatf("axi_rdata (word %0d)", rd_addr[r_count]),
                        axi_rdata, expect_read(rd_addr[r_count]));
            check_value("axi_rresp", 32'(axi_rresp), 32'h0);
            r_count++;
         end
      end
   end

   initial
   begin
      wait (uut.u_assertions.fail_count != 0);
      stop_on_error("A protocol assertion in the bound checker failed");
   end

   initial
   begin
      #(watchdog_ns);
      stop_on_error("Watchdog timeout, responses did not arrive in time");
   end

   initial
   begin
      void'($urandom(32'ha2ce_22fd));
      rst_n       = 1'b0;
      axi_awaddr  = '0;
      axi_awvalid = 1'b0;
      axi_wdata   = '0;
      axi_wvalid  = 1'b0;
      axi_bready  = 1'b0;
      axi_araddr  = '0;
      axi_arvalid = 1'b0;
      axi_rready  = 1'b0;
      gen_idle    = 1'b0;
      moves_ready = 1'b0;
      move_ready  = 1'b0;
      move_count  = '0;
      n_wr        = 0;
      n_rd        = 0;
      b_count     = 0;
      r_count     = 0;
      for (int i = 0; i < 16; i++)
         reg_model[i] = 32'h0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_outputs();
      check_value("axi_bvalid", 32'(axi_bvalid), 32'h0);
      check_value("axi_rvalid", 32'(axi_rvalid), 32'h0);
      readback_round();
      for (int r = 0; r < `TB_NUM_ROUNDS - 2; r++)
      begin
         plan_round(1'b1);
         run_round();
      end
      readback_round();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- move_ctrl_top.f
+incdir+include
verilog/chess_pkg.sv
verilog/bus_pkg.sv
verilog/req_queue.sv
verilog/axi_wr_front.sv
verilog/axi_rd_front.sv
verilog/reg_arbiter.sv
verilog/ctrl_reg_bank.sv
verilog/move_ctrl_top.sv
verif/move_ctrl_assertions.sv
verif/move_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the move control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module move_ctrl_tb \
   -f move_ctrl_top.f \
   -o move_ctrl_sim

./obj_dir/move_ctrl_sim
